// File: tiny_core.f
verilog/riscv_pkg.sv
verilog/core_pkg.sv
verilog/fetch.sv
verilog/decode_and_issue.sv
verilog/register_file.sv
verilog/alu_unit.sv
verilog/branch_unit.sv
verilog/tiny_core.sv
bench/tiny_core_tb.sv

// File: Bender.yml
package:
  name: tiny_core

sources:
  - verilog/riscv_pkg.sv
  - verilog/core_pkg.sv
  - verilog/fetch.sv
  - verilog/decode_and_issue.sv
  - verilog/register_file.sv
  - verilog/alu_unit.sv
  - verilog/branch_unit.sv
  - verilog/tiny_core.sv
  - target: test
    files:
      - bench/tiny_core_tb.sv

// File: bench/tiny_core_tb.sv
`timescale 1ns/1ps

module tiny_core_tb;
    import riscv_pkg::*;
    import core_pkg::*;

    localparam addr_t       RESET_VECTOR  = '0;
    localparam int          CLK_HALF      = 10;
    localparam int          RESET_CYCLES  = 3;
    localparam int          MAX_PROG_LEN  = 64;
    localparam int          NUM_TESTS     = 6;
    localparam int          MEM_WORDS     = 256;
    localparam logic [31:0] SEED          = 32'hab4411bc;
    // Ten cycles per instruction, plus reset and drain time per test
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * (MAX_PROG_LEN * 10 + 40);

    logic    clk;
    logic    arst_n;
    addr_t   imem_addr;
    logic    imem_rd;
    instr_t  imem_rdata;
    retire_t retire;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] prog [$];
    retire_t     retired [$];

    // Reference state of the ISA model
    data_t mregs [32];
    addr_t mpc;

    int value_errors;
    int other_errors;

    tiny_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rd    (imem_rd),
        .imem_rdata (imem_rdata),
        .retire     (retire)
    );

    always begin
        #CLK_HALF;
        clk = ~clk;
    end

    // Synchronous instruction memory, holds its word while imem_rd is low
    always @(posedge clk) begin
        if (imem_rd) begin
            imem_rdata <= imem[imem_addr[9:2]];
        end
    end

    // Retire is a one-cycle pulse, so the falling edge catches each one once
    always @(negedge clk) begin
        if (arst_n && retire.valid) begin
            retired.push_back(retire);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////
    // Instruction encoding

    function automatic logic [31:0] r_format(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                             logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_format(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                             reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_format(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] b_format(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                             logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] j_format(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic logic [11:0] random_imm12();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    function automatic logic [19:0] random_upper();
        logic [31:0] r;
        r = $urandom();
        return r[19:0];
    endfunction

    function automatic logic [4:0] random_shamt();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // LUI then ADDI, with the upper part rounded for the sign of the low part
    task automatic set_reg(input reg_addr_t rd, input data_t value);
        data_t hi;
        hi = (value + 32'h800) >> 12;
        emit(u_format(hi[19:0], rd, LUI));
        emit(i_format(value[11:0], rd, F3_ADD_SUB, rd, OP_IMM));
    endtask

    task automatic push_op(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2);
        emit(r_format(f7, rs2, rs1, f3, rd, OP));
    endtask

    ////////////////////
    // ISA reference model

    function automatic data_t alu_ref(logic [2:0] f3, logic alt, data_t a, data_t b);
        data_t r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic model_step(input logic [31:0] word, output retire_t exp);
        logic [6:0] opc;
        logic [2:0] f3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        data_t      a;
        data_t      b;
        data_t      imm_i;
        data_t      imm_u;
        data_t      imm_b;
        data_t      imm_j;
        data_t      val;
        addr_t      next_pc;
        logic       writes;
        logic       alt;
        logic       taken;
        opc     = word[6:0];
        rd      = word[11:7];
        f3      = word[14:12];
        rs1     = word[19:15];
        rs2     = word[24:20];
        a       = mregs[rs1];
        b       = mregs[rs2];
        imm_i   = {{20{word[31]}}, word[31:20]};
        imm_u   = {word[31:12], 12'b0};
        imm_b   = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        imm_j   = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        alt     = word[30] && (f3 == 3'b101 || (opc == OP && f3 == 3'b000));
        next_pc = mpc + 4;
        writes  = 1'b0;
        val     = '0;
        taken   = 1'b0;
        case (opc)
            OP_IMM: begin
                writes = 1'b1;
                val    = alu_ref(f3, alt, a, imm_i);
            end
            OP: begin
                writes = 1'b1;
                val    = alu_ref(f3, alt, a, b);
            end
            LUI: begin
                writes = 1'b1;
                val    = imm_u;
            end
            AUIPC: begin
                writes = 1'b1;
                val    = mpc + imm_u;
            end
            BRANCH: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    3'b111:  taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = mpc + imm_b;
                end
            end
            JAL: begin
                writes  = 1'b1;
                val     = mpc + 4;
                next_pc = mpc + imm_j;
            end
            JALR: begin
                writes  = 1'b1;
                val     = mpc + 4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: writes = 1'b0;
        endcase
        exp.valid = 1'b1;
        exp.pc    = mpc;
        exp.rd    = (writes && rd != '0) ? rd : '0;
        exp.value = (writes && rd != '0) ? val : '0;
        if (writes && rd != '0) begin
            mregs[rd] = val;
        end
        mpc = next_pc;
    endtask

    ////////////////////
    // Compare tasks

    task automatic check_retire(input string test, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("ERR %s: expected pc=%h rd=%0d value=%h, actual pc=%h rd=%0d value=%h",
                     test, exp.pc, exp.rd, exp.value, act.pc, act.rd, act.value);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string test, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR %s: expected addr=%h, actual addr=%h", test, exp, act);
            value_errors++;
        end
    endtask

    ////////////////////
    // Program runner

    task automatic run_program(input string name);
        retire_t exp_q [$];
        retire_t e;
        int      i;
        int      idx;
        int      steps;
        int      cycles;
        int      limit;
        if (prog.size() > MAX_PROG_LEN) begin
            $display("%s: program of %0d words is longer than the watchdog allows",
                     name, prog.size());
            other_errors++;
        end
        @(negedge clk);
        arst_n = 1'b0;
        // Filler is ADDI x0 with the byte address as immediate
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = i_format(12'(i * 4), 5'd0, F3_ADD_SUB, 5'd0, OP_IMM);
        end
        for (i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end
        for (i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        mpc   = RESET_VECTOR;
        steps = 0;
        while (mpc < RESET_VECTOR + prog.size() * 4 && steps < 10 * prog.size()) begin
            idx = (mpc - RESET_VECTOR) >> 2;
            model_step(prog[idx], e);
            exp_q.push_back(e);
            steps++;
        end
        retired.delete();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (retire.valid) begin
                $display("%s: retire went valid while reset was asserted", name);
                other_errors++;
            end
            check_addr(name, RESET_VECTOR, imem_addr);
        end
        arst_n = 1'b1;
        check_addr(name, RESET_VECTOR, imem_addr);
        if (!imem_rd) begin
            $display("%s: the first fetch after reset has no read strobe", name);
            other_errors++;
        end
        limit  = 10 * prog.size() + 20;
        cycles = 0;
        while (retired.size() < exp_q.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (retired.size() < exp_q.size()) begin
            $display("%s: only %0d of %0d instructions retired within %0d cycles",
                     name, retired.size(), exp_q.size(), limit);
            other_errors++;
        end
        for (i = 0; i < exp_q.size() && i < retired.size(); i++) begin
            check_retire(name, exp_q[i], retired[i]);
        end
        prog.delete();
    endtask

    ////////////////////
    // Directed tests

    task automatic test_reset();
        emit(i_format(12'd7, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM));
        emit(i_format(12'd1, 5'd1, F3_ADD_SUB, 5'd2, OP_IMM));
        emit(i_format(12'd3, 5'd2, F3_XOR, 5'd3, OP_IMM));
        run_program("reset");
    endtask

    task automatic test_reg_imm();
        set_reg(5'd1, $urandom());
        set_reg(5'd2, $urandom());
        emit(i_format(random_imm12(), 5'd1, F3_ADD_SUB, 5'd3, OP_IMM));
        emit(i_format(random_imm12(), 5'd1, F3_SLT, 5'd4, OP_IMM));
        emit(i_format(random_imm12(), 5'd2, F3_SLTU, 5'd5, OP_IMM));
        emit(i_format(random_imm12(), 5'd1, F3_XOR, 5'd6, OP_IMM));
        emit(i_format(random_imm12(), 5'd2, F3_OR, 5'd7, OP_IMM));
        emit(i_format(random_imm12(), 5'd1, F3_AND, 5'd8, OP_IMM));
        emit(i_format({7'b0, random_shamt()}, 5'd1, F3_SLL, 5'd9, OP_IMM));
        emit(i_format({7'b0, random_shamt()}, 5'd2, F3_SRL_SRA, 5'd10, OP_IMM));
        emit(i_format({F7_ALT, random_shamt()}, 5'd1, F3_SRL_SRA, 5'd11, OP_IMM));
        // Depends on the SRAI right before it
        emit(i_format(random_imm12(), 5'd11, F3_ADD_SUB, 5'd12, OP_IMM));
        run_program("reg_imm");
    endtask

    task automatic test_reg_reg();
        set_reg(5'd1, $urandom());
        set_reg(5'd2, $urandom());
        // Each result feeds the next
        push_op(7'b0, F3_ADD_SUB, 5'd3, 5'd1, 5'd2);
        push_op(F7_ALT, F3_ADD_SUB, 5'd4, 5'd3, 5'd1);
        push_op(F7_ALT, F3_SRL_SRA, 5'd5, 5'd4, 5'd2);
        push_op(7'b0, F3_SLTU, 5'd6, 5'd5, 5'd4);
        push_op(7'b0, F3_SLL, 5'd7, 5'd6, 5'd3);
        push_op(7'b0, F3_SLT, 5'd8, 5'd7, 5'd5);
        push_op(7'b0, F3_XOR, 5'd9, 5'd8, 5'd4);
        push_op(7'b0, F3_SRL_SRA, 5'd10, 5'd9, 5'd1);
        push_op(7'b0, F3_OR, 5'd11, 5'd10, 5'd2);
        push_op(7'b0, F3_AND, 5'd12, 5'd11, 5'd9);
        // x0 takes the write but keeps reading zero
        push_op(7'b0, F3_ADD_SUB, 5'd0, 5'd1, 5'd2);
        push_op(7'b0, F3_ADD_SUB, 5'd13, 5'd0, 5'd1);
        push_op(F7_ALT, F3_ADD_SUB, 5'd14, 5'd0, 5'd0);
        run_program("reg_reg");
    endtask

    task automatic test_upper();
        emit(u_format(random_upper(), 5'd1, LUI));
        emit(u_format(random_upper(), 5'd2, AUIPC));
        emit(u_format(random_upper(), 5'd3, AUIPC));
        emit(u_format(random_upper(), 5'd4, LUI));
        push_op(7'b0, F3_ADD_SUB, 5'd5, 5'd1, 5'd2);
        run_program("upper");
    endtask

    task automatic test_branches();
        data_t a;
        data_t b;
        int    c;
        // Opposite signs so the signed and unsigned compares disagree
        a = $urandom() | 32'h8000_0000;
        b = $urandom() & 32'h7fff_ffff;
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        for (c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                emit(b_format(13'd8, 5'd2, 5'd1, 3'(c)));
                emit(i_format(12'd1, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
                emit(i_format(12'd1, 5'd6, F3_ADD_SUB, 5'd6, OP_IMM));
                emit(b_format(13'd8, 5'd1, 5'd2, 3'(c)));
                emit(i_format(12'd1, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
                emit(i_format(12'd1, 5'd6, F3_ADD_SUB, 5'd6, OP_IMM));
                emit(b_format(13'd8, 5'd1, 5'd1, 3'(c)));
                emit(i_format(12'd1, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
                emit(i_format(12'd1, 5'd6, F3_ADD_SUB, 5'd6, OP_IMM));
            end
        end
        run_program("branches");
    endtask

    task automatic test_jumps();
        logic [11:0] target;
        emit(j_format(21'd12, 5'd1));
        emit(i_format(12'd1, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
        emit(i_format(12'd2, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
        emit(i_format(12'd0, 5'd1, F3_ADD_SUB, 5'd6, OP_IMM));
        // JALR lands three words on, with bit 0 of the sum dropped
        target = 12'((prog.size() + 3) * 4);
        emit(i_format(target, 5'd0, F3_ADD_SUB, 5'd7, OP_IMM));
        emit(i_format(12'd1, 5'd7, 3'b000, 5'd8, JALR));
        emit(i_format(12'd4, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
        push_op(7'b0, F3_ADD_SUB, 5'd9, 5'd8, 5'd6);
        emit(j_format(21'd8, 5'd0));
        emit(i_format(12'd8, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM));
        emit(i_format(random_imm12(), 5'd5, F3_ADD_SUB, 5'd10, OP_IMM));
        run_program("jumps");
    endtask

    ////////////////////
    // Main sequence
    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        imem_rdata   = 32'h0000_0013;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));

        test_reset();
        test_reg_imm();
        test_reg_reg();
        test_upper();
        test_branches();
        test_jumps();

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/tiny_core.sv
`timescale 1ns/1ps

module tiny_core #(
    parameter riscv_pkg::addr_t RESET_VECTOR = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    output riscv_pkg::addr_t  imem_addr,
    output logic              imem_rd,
    input  riscv_pkg::instr_t imem_rdata,
    output core_pkg::retire_t retire
);
    import riscv_pkg::*;
    import core_pkg::*;

    fetch_packet_t fetch_pkt;
    issue_packet_t issue;
    redirect_t     redirect;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    data_t         rs1_data;
    data_t         rs2_data;
    logic          stall;

    ////////////////////
    // Front end
    fetch #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_rd   (imem_rd),
        .fetch     (fetch_pkt)
    );

    decode_and_issue u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch    (fetch_pkt),
        .instr    (imem_rdata),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .stall    (stall),
        .issue    (issue)
    );

    // Written from the retire packet
    register_file u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire)
    );

    ////////////////////
    // Execute
    alu_unit u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .result (retire)
    );

    branch_unit u_branch (
        .clk      (clk),
        .issue    (issue),
        .redirect (redirect)
    );

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                    clk,
    input  core_pkg::issue_packet_t issue,
    output core_pkg::redirect_t     redirect
);
    import riscv_pkg::*;
    import core_pkg::*;

    logic  taken;
    addr_t base;
    addr_t sum;

    always_comb begin
        case (issue.br_op)
            BR_BEQ:  taken = issue.op_a == issue.rs2_val;
            BR_BNE:  taken = issue.op_a != issue.rs2_val;
            BR_BLT:  taken = $signed(issue.op_a) < $signed(issue.rs2_val);
            BR_BGE:  taken = $signed(issue.op_a) >= $signed(issue.rs2_val);
            BR_BLTU: taken = issue.op_a < issue.rs2_val;
            BR_BGEU: taken = issue.op_a >= issue.rs2_val;
            // Jumps always redirect
            default: taken = 1'b1;
        endcase
    end

    ////////////////////
    // Target
    assign base = (issue.br_op == BR_JALR) ? issue.op_a : issue.pc;
    assign sum  = base + issue.imm;

    assign redirect.flush  = issue.valid && issue.is_branch && taken;
    assign redirect.target = (issue.br_op == BR_JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

    // Fetch has no path for misaligned words
    a_target_aligned: assert property (@(posedge clk)
        redirect.flush |-> redirect.target[1:0] == 2'b00)
        else $error("misaligned target %h from pc %h", redirect.target, issue.pc);

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  core_pkg::issue_packet_t issue,
    output core_pkg::retire_t       result
);
    import riscv_pkg::*;
    import core_pkg::*;

    data_t value;

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  value = issue.op_a + issue.op_b;
            ALU_SUB:  value = issue.op_a - issue.op_b;
            ALU_SLL:  value = issue.op_a << issue.op_b[4:0];
            ALU_SLT:  value = data_t'($signed(issue.op_a) < $signed(issue.op_b));
            ALU_SLTU: value = data_t'(issue.op_a < issue.op_b);
            ALU_XOR:  value = issue.op_a ^ issue.op_b;
            ALU_SRL:  value = issue.op_a >> issue.op_b[4:0];
            ALU_SRA:  value = $unsigned($signed(issue.op_a) >>> issue.op_b[4:0]);
            ALU_OR:   value = issue.op_a | issue.op_b;
            ALU_AND:  value = issue.op_a & issue.op_b;
            ALU_PASS: value = issue.op_b;
            // Return address of JAL and JALR
            ALU_LINK: value = issue.pc + addr_t'(4);
            default:  value = '0;
        endcase
    end

    ////////////////////
    // Writeback and retire register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result.valid <= issue.valid;
            result.pc    <= issue.pc;
            result.rd    <= issue.uses_rd ? issue.rd : '0;
            result.value <= issue.uses_rd ? value : '0;
        end
    end

    // Decode trims the amount before it reaches execute
    a_shift_amount: assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid && (issue.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA})
        |-> issue.op_b < 32)
        else $error("shift amount %0d at pc %h", issue.op_b, issue.pc);

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_pkg::reg_addr_t rs1_addr,
    input  riscv_pkg::reg_addr_t rs2_addr,
    output riscv_pkg::data_t     rs1_data,
    output riscv_pkg::data_t     rs2_data,
    input  core_pkg::retire_t    wb
);
    import riscv_pkg::*;

    // x0 has no storage
    data_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    function automatic data_t read_port(reg_addr_t addr);
        data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.valid && wb.rd == addr) begin
            value = wb.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: verilog/decode_and_issue.sv
`timescale 1ns/1ps

module decode_and_issue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  core_pkg::fetch_packet_t fetch,
    input  riscv_pkg::instr_t       instr,
    input  core_pkg::redirect_t     redirect,
    output riscv_pkg::reg_addr_t    rs1_addr,
    output riscv_pkg::reg_addr_t    rs2_addr,
    input  riscv_pkg::data_t        rs1_data,
    input  riscv_pkg::data_t        rs2_data,
    output logic                    stall,
    output core_pkg::issue_packet_t issue
);
    import riscv_pkg::*;
    import core_pkg::*;

    logic [6:0]    opcode;
    logic          known_op;
    logic          uses_rs1;
    logic          uses_rs2;
    logic          writes_rd;
    logic          is_shift;
    alu_op_t       alu_op;
    br_op_t        br_op;
    data_t         imm;
    data_t         src_b;
    issue_packet_t issue_next;

    assign opcode   = instr.r.opcode;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    ////////////////////
    // Format decode
    always_comb begin
        known_op  = 1'b1;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        imm       = '0;
        case (opcode)
            OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_IMM, JALR: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            LUI, AUIPC: begin
                writes_rd = 1'b1;
                imm       = {instr.u.imm_31_12, 12'b0};
            end
            BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                            instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            JAL: begin
                writes_rd = 1'b1;
                imm       = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                             instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            // Anything else passes through as a no-op
            default: known_op = 1'b0;
        endcase
    end

    // ALU and branch operation select
    always_comb begin
        alu_op = ALU_ADD;
        br_op  = BR_BEQ;
        case (opcode)
            OP, OP_IMM: begin
                case (instr.r.funct3)
                    F3_ADD_SUB: alu_op = (opcode == OP && instr.r.funct7 == F7_ALT) ?
                                         ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = (instr.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            LUI: alu_op = ALU_PASS;
            BRANCH: begin
                case (instr.b.funct3)
                    F3_BEQ:  br_op = BR_BEQ;
                    F3_BNE:  br_op = BR_BNE;
                    F3_BLT:  br_op = BR_BLT;
                    F3_BGE:  br_op = BR_BGE;
                    F3_BLTU: br_op = BR_BLTU;
                    F3_BGEU: br_op = BR_BGEU;
                    default: br_op = BR_BEQ;
                endcase
            end
            JAL: begin
                alu_op = ALU_LINK;
                br_op  = BR_JAL;
            end
            JALR: begin
                alu_op = ALU_LINK;
                br_op  = BR_JALR;
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    ////////////////////
    // Hazard against the instruction in execute
    assign stall = fetch.valid && issue.valid && issue.uses_rd &&
                   ((uses_rs1 && rs1_addr != '0 && rs1_addr == issue.rd) ||
                    (uses_rs2 && rs2_addr != '0 && rs2_addr == issue.rd));

    // Shift amount keeps only its low five bits
    assign is_shift = alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA};
    assign src_b    = (opcode == OP) ? rs2_data : imm;

    always_comb begin
        issue_next.valid     = fetch.valid && !stall && !redirect.flush;
        issue_next.pc        = fetch.pc;
        issue_next.rd        = instr.r.rd;
        issue_next.uses_rd   = writes_rd && (instr.r.rd != '0);
        issue_next.alu_op    = alu_op;
        issue_next.br_op     = br_op;
        issue_next.is_branch = opcode inside {BRANCH, JAL, JALR};
        issue_next.op_a      = (opcode inside {AUIPC, JAL}) ? fetch.pc : rs1_data;
        issue_next.op_b      = is_shift ? data_t'(src_b[4:0]) : src_b;
        issue_next.rs2_val   = rs2_data;
        issue_next.imm       = imm;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue <= '0;
        end else begin
            issue <= issue_next;
        end
    end

    // Squashed words may hold anything, so only live ones are checked
    a_known_opcode: assert property (@(posedge clk) disable iff (!arst_n)
        fetch.valid && !redirect.flush |-> known_op)
        else $error("unknown opcode %b at pc %h", opcode, fetch.pc);

endmodule

// File: verilog/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter riscv_pkg::addr_t RESET_VECTOR = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  core_pkg::redirect_t     redirect,
    output riscv_pkg::addr_t        imem_addr,
    output logic                    imem_rd,
    output core_pkg::fetch_packet_t fetch
);
    import riscv_pkg::*;

    // Address of the next sequential fetch
    addr_t pc;

    ////////////////////
    // Memory request

    // Redirect target goes out in the same cycle as the flush
    assign imem_addr = redirect.flush ? redirect.target : pc;

    // Flush wins over a stall
    assign imem_rd = redirect.flush || !stall;

    ////////////////////
    // PC and arriving word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= RESET_VECTOR;
            fetch.valid <= 1'b0;
            fetch.pc    <= RESET_VECTOR;
        end else if (imem_rd) begin
            pc          <= imem_addr + addr_t'(4);
            fetch.valid <= 1'b1;
            fetch.pc    <= imem_addr;
        end
        // On a stall the memory holds its word, so the packet holds too
    end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS,
        ALU_LINK
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_t;

    ////////////////////
    // Stage packets

    // Word arriving on imem_rdata
    typedef struct packed {
        logic             valid;
        riscv_pkg::addr_t pc;
    } fetch_packet_t;

    // Execute stage register
    typedef struct packed {
        logic                 valid;
        riscv_pkg::addr_t     pc;
        riscv_pkg::reg_addr_t rd;
        logic                 uses_rd;
        alu_op_t              alu_op;
        br_op_t               br_op;
        logic                 is_branch;
        riscv_pkg::data_t     op_a;
        riscv_pkg::data_t     op_b;
        riscv_pkg::data_t     rs2_val;
        riscv_pkg::data_t     imm;
    } issue_packet_t;

    typedef struct packed {
        logic             flush;
        riscv_pkg::addr_t target;
    } redirect_t;

    // Also serves as the register file write port
    typedef struct packed {
        logic                 valid;
        riscv_pkg::addr_t     pc;
        riscv_pkg::reg_addr_t rd;
        riscv_pkg::data_t     value;
    } retire_t;

endpackage

// File: verilog/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    ////////////////////
    // funct3 and funct7 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    ////////////////////
    // Instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    // Same word, read through the view the opcode selects
    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

endpackage
